// ==== source/ntm_fixed_defines.svh ====
////////////////////////////////////////
// Q-format of the dot-product datapath
// Included by the package and by stages that shift by the fraction
////////////////////////////////////////

`ifndef NTM_FIXED_DEFINES_SVH
`define NTM_FIXED_DEFINES_SVH

// Total width of one fixed-point value, sign included
`define NTM_DATA_WIDTH 32

// Fraction bits, Q16.16 with the width above
`define NTM_FRAC_BITS 16

`endif

// ==== source/ntm_fixed_pkg.sv ====
////////////////////////////////////////
// Fixed-point types, limits and saturation helpers
////////////////////////////////////////

`default_nettype none

`include "ntm_fixed_defines.svh"

package ntm_fixed_pkg;

  // One operand, product or sum
  typedef logic signed [`NTM_DATA_WIDTH-1:0] fixed_t;
  // Full product or unsaturated sum
  typedef logic signed [2*`NTM_DATA_WIDTH-1:0] wide_t;

  // Accumulator control
  typedef enum logic {
    ACC_COLLECT,
    ACC_DELIVER
  } acc_state_t;

  // Range limits of fixed_t
  localparam fixed_t FIXED_MAX = {1'b0, {(`NTM_DATA_WIDTH-1){1'b1}}};
  localparam fixed_t FIXED_MIN = {1'b1, {(`NTM_DATA_WIDTH-1){1'b0}}};

  // High when the wide value is representable as fixed_t
  function automatic logic fixed_fits(input wide_t value);
    return (value <= wide_t'(FIXED_MAX)) && (value >= wide_t'(FIXED_MIN));
  endfunction

  // Clamp to the nearest limit when out of range
  function automatic fixed_t fixed_saturate(input wide_t value);
    if (value > wide_t'(FIXED_MAX)) return FIXED_MAX;
    if (value < wide_t'(FIXED_MIN)) return FIXED_MIN;
    return fixed_t'(value);
  endfunction

endpackage

`default_nettype wire

// ==== source/ntm_fixed_stage_if.sv ====
////////////////////////////////////////
// Product link from multiplier to accumulator
// Valid/ready, one product per transfer
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

interface ntm_fixed_stage_if;

  import ntm_fixed_pkg::*;

  // Handshake
  logic   valid;
  logic   ready;

  // Payload
  fixed_t data;
  // Product was clamped
  logic   overflow;
  // Closes the current vector
  logic   last;

  // Producer side, multiplier output
  modport source (
    output valid,
    output data,
    output overflow,
    output last,
    input  ready
  );

  // Consumer side, accumulator input
  modport sink (
    input  valid,
    input  data,
    input  overflow,
    input  last,
    output ready
  );

endinterface

`default_nettype wire

// ==== source/ntm_scalar_fixed_multiplier.sv ====
////////////////////////////////////////
// Fixed-point multiplier stage
// Truncated, saturated product of one operand pair per transfer
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "ntm_fixed_defines.svh"

module ntm_scalar_fixed_multiplier (
  input  wire                   CLK,
  input  wire                   RST,

  // Operand pair in
  input  wire                   in_valid,
  output logic                  in_ready,
  input  wire ntm_fixed_pkg::fixed_t in_a,
  input  wire ntm_fixed_pkg::fixed_t in_b,
  input  wire                   in_last,

  // Product out
  ntm_fixed_stage_if.source     prod
);

  import ntm_fixed_pkg::*;

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  // Arithmetic path
  wide_t  product_full;
  wide_t  product_shift;
  fixed_t product_sat;
  logic   product_ovf;

  // Input transfer this cycle
  logic   load;

  // Output register
  logic   valid_q;
  fixed_t data_q;
  logic   ovf_q;
  logic   last_q;

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  // Both operands sign-extended before multiply, no bits lost
  assign product_full  = wide_t'(in_a) * wide_t'(in_b);

  // Drop fraction bits, arithmetic shift floors toward minus infinity
  assign product_shift = product_full >>> `NTM_FRAC_BITS;

  // Clamp out-of-range results
  assign product_sat   = fixed_saturate(product_shift);
  assign product_ovf   = !fixed_fits(product_shift);

  ////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////

  // Register empty, or draining this cycle
  assign in_ready = !valid_q || prod.ready;
  assign load     = in_valid && in_ready;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (prod.ready) begin
      // Held product taken, nothing new
      valid_q <= 1'b0;
    end
  end

  // Payload only moves on a load
  always_ff @(posedge CLK) begin
    if (load) begin
      data_q <= product_sat;
      ovf_q  <= product_ovf;
      last_q <= in_last;
    end
  end

  // Drive the link
  assign prod.valid    = valid_q;
  assign prod.data     = data_q;
  assign prod.overflow = ovf_q;
  assign prod.last     = last_q;

endmodule

`default_nettype wire

// ==== source/ntm_fixed_accumulator.sv ====
////////////////////////////////////////
// Saturating accumulator stage
// Sums one vector of products, holds the total until taken
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module ntm_fixed_accumulator (
  input  wire                   CLK,
  input  wire                   RST,

  // Products in
  ntm_fixed_stage_if.sink       prod,

  // Finished sum out
  output logic                  out_valid,
  input  wire                   out_ready,
  output ntm_fixed_pkg::fixed_t out_data,
  output logic                  out_overflow
);

  import ntm_fixed_pkg::*;

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  acc_state_t state;

  // Running total and sticky flag
  fixed_t sum_q;
  logic   ovf_q;

  // Start point for the next addition
  fixed_t sum_base;
  logic   ovf_base;

  // Adder path
  wide_t  sum_wide;
  fixed_t sum_next;
  logic   ovf_next;

  // Events
  logic   take;
  logic   delivered;

  ////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////

  // Blocked while a result waits, except in the cycle it leaves
  assign prod.ready = (state == ACC_COLLECT) || out_ready;
  assign take       = prod.valid && prod.ready;
  assign delivered  = (state == ACC_DELIVER) && out_ready;

  ////////////////////////////////////////
  // Adder
  ////////////////////////////////////////

  // Fresh vector when the old result is leaving
  assign sum_base = (state == ACC_DELIVER) ? '0 : sum_q;
  assign ovf_base = (state == ACC_DELIVER) ? 1'b0 : ovf_q;

  // One guard bit is plenty, wide_t keeps it simple
  assign sum_wide = wide_t'(sum_base) + wide_t'(prod.data);
  assign sum_next = fixed_saturate(sum_wide);

  // Sticky over the vector, product and sum events alike
  assign ovf_next = ovf_base || prod.overflow || !fixed_fits(sum_wide);

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= ACC_COLLECT;
      sum_q <= '0;
      ovf_q <= 1'b0;
    end else if (take) begin
      sum_q <= sum_next;
      ovf_q <= ovf_next;
      // Last product ends the vector
      state <= prod.last ? ACC_DELIVER : ACC_COLLECT;
    end else if (delivered) begin
      // Result gone, clear for the next vector
      sum_q <= '0;
      ovf_q <= 1'b0;
      state <= ACC_COLLECT;
    end
  end

  // Result outputs
  assign out_valid    = (state == ACC_DELIVER);
  assign out_data     = sum_q;
  assign out_overflow = ovf_q;

endmodule

`default_nettype wire

// ==== source/ntm_dot_product.sv ====
////////////////////////////////////////
// Streaming fixed-point dot product, top level
// Operand pairs in with last flag, one sum per vector out
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module ntm_dot_product (
  input  wire                   CLK,
  input  wire                   RST,

  // Operand stream
  input  wire                   in_valid,
  output logic                  in_ready,
  input  wire ntm_fixed_pkg::fixed_t in_a,
  input  wire ntm_fixed_pkg::fixed_t in_b,
  input  wire                   in_last,

  // Result stream
  output logic                  out_valid,
  input  wire                   out_ready,
  output ntm_fixed_pkg::fixed_t out_data,
  output logic                  out_overflow
);

  ////////////////////////////////////////
  // Stage link
  ////////////////////////////////////////

  // One product in flight between the stages
  ntm_fixed_stage_if stage_if ();

  ////////////////////////////////////////
  // Stages
  ////////////////////////////////////////

  // Stage 1, multiply and clamp
  ntm_scalar_fixed_multiplier multiplier_i (
    .CLK      (CLK),
    .RST      (RST),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_a     (in_a),
    .in_b     (in_b),
    .in_last  (in_last),
    .prod     (stage_if.source)
  );

  // Stage 2, sum per vector
  ntm_fixed_accumulator accumulator_i (
    .CLK          (CLK),
    .RST          (RST),
    .prod         (stage_if.sink),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_data     (out_data),
    .out_overflow (out_overflow)
  );

endmodule

`default_nettype wire

// ==== bench/ntm_dot_product_tb.sv ====
////////////////////////////////////////
// Random-stimulus testbench for the dot-product unit
// Wide-integer model and scoreboard checked on every output transfer
////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "ntm_fixed_defines.svh"

module ntm_dot_product_tb;

  import ntm_fixed_pkg::*;

  localparam int     TIMEOUT = 200;
  localparam longint TOP_VAL = (64'sd1 <<< (`NTM_DATA_WIDTH - 1)) - 1;
  localparam longint BOT_VAL = -(64'sd1 <<< (`NTM_DATA_WIDTH - 1));
  // Operand kinds per vector
  localparam int SMALL = 0, PROD_OVF = 1, SUM_OVF = 2, ALTERNATE = 3, MIXED = 4;

  logic   CLK = 1'b0;
  logic   RST;
  logic   in_valid;
  logic   in_ready;
  logic   in_last;
  fixed_t in_a;
  fixed_t in_b;
  logic   out_valid;
  logic   out_ready = 1'b0;
  logic   out_overflow;
  fixed_t out_data;

  // Scoreboard filled by the driver and read in order by the monitor
  fixed_t exp_data[$];
  logic   exp_ovf[$];
  int     exp_next = 0;
  // Cycle of each last transfer
  int     last_at[$];
  int     lat_next = 0;
  int     neg_count = 0;
  int     results = 0;
  int     checks = 0;
  int     errors = 0;
  int     miss_errors = 0;
  int     tests = 0;
  bit     stall_en = 1'b0;
  bit     check_latency = 1'b0;

  ntm_dot_product ntm_dot_product_i (
    .CLK          (CLK),
    .RST          (RST),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .in_a         (in_a),
    .in_b         (in_b),
    .in_last      (in_last),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_data     (out_data),
    .out_overflow (out_overflow)
  );

  always #4 CLK = ~CLK;

  // Random back-pressure with ready three quarters of the time
  always @(posedge CLK) begin
    out_ready <= stall_en ? ($urandom_range(0, 3) != 0) : 1'b1;
  end

  ////////////////////////////////////////
  // Model helpers
  ////////////////////////////////////////

  function automatic bit out_of_range(input longint value);
    return (value > TOP_VAL) || (value < BOT_VAL);
  endfunction

  function automatic longint clamp_q16(input longint value);
    if (value > TOP_VAL) return TOP_VAL;
    if (value < BOT_VAL) return BOT_VAL;
    return value;
  endfunction

  task automatic stop_on_timeout(input string what);
    $display("Timed out after %0d cycles waiting for %s at %0t", TIMEOUT, what, $time);
    $display("** FAIL **");
    $finish;
  endtask

  ////////////////////////////////////////
  // Monitor sampled on the falling edge
  ////////////////////////////////////////

  always @(negedge CLK) begin
    if (!RST) begin
      neg_count++;
      if (in_valid && in_ready && in_last) last_at.push_back(neg_count);
      if (out_valid && out_ready) begin
        results++;
        checks++;
        assert (exp_next < exp_data.size()) else begin
          $display("Result at %0t arrived with no vector outstanding", $time);
          errors++;
        end
        if (exp_next < exp_data.size()) begin
          checks += 2;
          assert (out_data == exp_data[exp_next]) else begin
            $display("FAILED %0t: sum %0d, expected %0d", $time, out_data,
                     exp_data[exp_next]);
            errors++;
          end
          assert (out_overflow == exp_ovf[exp_next]) else begin
            $display("FAILED %0t: overflow %0b, expected %0b", $time, out_overflow,
                     exp_ovf[exp_next]);
            errors++;
          end
          exp_next++;
        end
        // Result two cycles after the last pair when nothing stalls
        if (check_latency && lat_next < last_at.size()) begin
          checks++;
          assert (neg_count - last_at[lat_next] == 2) else begin
            $display("FAILED %0t: latency %0d cycles, expected 2", $time,
                     neg_count - last_at[lat_next]);
            errors++;
          end
        end
        lat_next++;
      end
    end
  end

  ////////////////////////////////////////
  // Driver
  ////////////////////////////////////////

  task automatic send_pair(input fixed_t a, input fixed_t b, input logic last);
    int waited;
    in_valid <= 1'b1;
    in_a     <= a;
    in_b     <= b;
    in_last  <= last;
    waited = 0;
    @(negedge CLK);
    while (!in_ready) begin
      if (waited >= TIMEOUT) stop_on_timeout("in_ready");
      @(negedge CLK);
      waited++;
    end
    // Transfer on this edge
    @(posedge CLK);
  endtask

  task automatic send_vector(input int kind, input bit gaps);
    fixed_t a[8];
    fixed_t b[8];
    longint prod;
    longint sum;
    logic   ovf;
    int     len;
    int     pick;
    bit     neg;
    len  = (kind == SUM_OVF) ? $urandom_range(5, 8) : $urandom_range(1, 8);
    pick = $urandom_range(0, len - 1);
    neg  = ($urandom_range(0, 1) == 1);
    sum  = 0;
    ovf  = 1'b0;
    for (int i = 0; i < len; i++) begin
      if (kind == SUM_OVF) begin
        // Same-sign products that fit but five of them exceed the range
        a[i] = fixed_t'($urandom_range(32'h0040_0000, 32'h007F_FFFF));
        b[i] = fixed_t'($urandom_range(32'h0080_0000, 32'h00BF_FFFF));
        if (neg) a[i] = -a[i];
      end else if (kind == PROD_OVF && i == pick) begin
        // Both above 256.0
        a[i] = fixed_t'($urandom_range(32'h0100_0000, 32'h7FFF_FFFF));
        b[i] = fixed_t'($urandom_range(32'h0100_0000, 32'h7FFF_FFFF));
        if (neg) a[i] = -a[i];
        if ($urandom_range(0, 1) == 1) b[i] = -b[i];
      end else begin
        // Within +-4.0
        a[i] = fixed_t'($urandom_range(0, 32'h0008_0000)) - 32'sh0004_0000;
        b[i] = fixed_t'($urandom_range(0, 32'h0008_0000)) - 32'sh0004_0000;
      end
      // Floor of the scaled product then clamp and saturating sum
      prod = (longint'(a[i]) * longint'(b[i])) >>> `NTM_FRAC_BITS;
      ovf  = ovf | out_of_range(prod);
      sum  = sum + clamp_q16(prod);
      ovf  = ovf | out_of_range(sum);
      sum  = clamp_q16(sum);
    end
    exp_data.push_back(fixed_t'(sum));
    exp_ovf.push_back(ovf);
    for (int i = 0; i < len; i++) begin
      send_pair(a[i], b[i], i == len - 1);
      if (gaps && $urandom_range(0, 2) == 0) begin
        in_valid <= 1'b0;
        repeat ($urandom_range(1, 3)) @(posedge CLK);
      end
    end
  endtask

  task automatic run_test(input string name, input int kind, input int vectors,
                          input bit stalls, input bit gaps, input bit latency);
    int err0;
    int res0;
    int miss;
    int vk;
    int waited;
    err0 = errors;
    res0 = results;
    miss = 0;
    stall_en      = stalls;
    check_latency = latency;
    repeat (2) @(posedge CLK);
    for (int v = 0; v < vectors; v++) begin
      vk = kind;
      if (kind == ALTERNATE) vk = (v % 2 == 0) ? PROD_OVF : SMALL;
      if (kind == MIXED) vk = $urandom_range(0, 2);
      send_vector(vk, gaps);
    end
    in_valid <= 1'b0;
    in_last  <= 1'b0;
    waited = 0;
    while (exp_next != exp_data.size()) begin
      if (waited >= TIMEOUT) stop_on_timeout("out_valid");
      @(negedge CLK);
      waited++;
    end
    @(posedge CLK);
    tests++;
    checks += 3;
    assert (results - res0 == vectors) else begin
      $display("Test %s received %0d results for %0d vectors", name, results - res0, vectors);
      miss++;
    end
    // Drained pipeline accepts input and holds no result
    @(negedge CLK);
    assert (!out_valid) else begin
      $display("Test %s shows a result pending after its last vector", name);
      miss++;
    end
    assert (in_ready) else begin
      $display("Test %s finds in_ready low with the pipeline empty", name);
      miss++;
    end
    miss_errors += miss;
    $display("Test %-14s vectors %3d  results %3d  errors %0d", name, vectors,
             results - res0, errors - err0 + miss);
  endtask

  initial begin
    void'($urandom(32'h2807_1437));
    RST      <= 1'b1;
    in_valid <= 1'b0;
    in_a     <= '0;
    in_b     <= '0;
    in_last  <= 1'b0;
    repeat (2) @(posedge CLK);
    RST <= 1'b0;
    run_test("small", SMALL, 20, 1'b0, 1'b1, 1'b0);
    run_test("product_clamp", PROD_OVF, 12, 1'b0, 1'b1, 1'b0);
    run_test("sum_saturate", SUM_OVF, 12, 1'b0, 1'b1, 1'b0);
    run_test("flag_clear", ALTERNATE, 12, 1'b0, 1'b1, 1'b0);
    run_test("stalls", MIXED, 30, 1'b1, 1'b1, 1'b0);
    run_test("latency", SMALL, 12, 1'b0, 1'b0, 1'b1);
    $display("Tests %0d  results %0d  checks %0d  errors %0d", tests, results, checks,
             errors + miss_errors);
    if (errors + miss_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+source
source/ntm_fixed_pkg.sv
source/ntm_fixed_stage_if.sv
source/ntm_scalar_fixed_multiplier.sv
source/ntm_fixed_accumulator.sv
source/ntm_dot_product.sv
bench/ntm_dot_product_tb.sv

// ==== Makefile ====
# Verilator build and run for the dot-product testbench

TOP = ntm_dot_product_tb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
